//--- boot_patch.mem
// Patch ROM image, one 16-bit hex word per line, word 0 first
4EF9
0040
0100
4E71
2F00
303C
0001
4E75
48E7
FFFE
4CDF
7FFF
4E73
0000
A5C3
5A3C

//--- boot_patch_rom.sv
`timescale 1ns/1ps

module boot_patch_rom (
    input  logic               clk30,
    input  logic               reset,
    input  logic               slave_reset_req,
    input  logic               cd_img_mounted,
    input  logic               config_auto_play,
    input  logic               audio_cd_in_tray,
    input  logic               rom_cs,
    input  cdi_bus_pkg::addr_t addr,
    output logic               rom_enabled,
    output cdi_bus_pkg::data_t rom_dout,
    output logic               rom_ack
);

    cdi_bus_pkg::data_t rom_mem [cdi_bus_pkg::ROM_WORDS];

    logic rom_blocked;
    logic sys_reset;

    initial $readmemh("boot_patch.mem", rom_mem);

    assign sys_reset = reset || slave_reset_req;

    // A reset from the slave means software went back to the shell,
    // so auto-play stays off until the next external reset
    always_ff @(posedge clk30) begin
        if (reset) begin
            rom_blocked <= 1'b0;
        end else if (slave_reset_req) begin
            rom_blocked <= 1'b1;
        end
    end

    // Only a mounted CD-i disc with auto-play on gets the patch
    assign rom_enabled = cd_img_mounted && config_auto_play && !audio_cd_in_tray && !rom_blocked;

    // One acknowledge pulse per access
    always_ff @(posedge clk30) begin
        if (sys_reset) begin
            rom_ack <= 1'b0;
        end else begin
            rom_ack <= rom_cs && !rom_ack;
        end
    end

    always_ff @(posedge clk30) begin
        if (rom_cs && !rom_ack) begin
            rom_dout <= rom_mem[addr[cdi_bus_pkg::ROM_ADDR_BITS:1]];
        end
    end

    a_ack_single: assert property (
        @(posedge clk30) disable iff (sys_reset)
        rom_ack |=> !rom_ack
    ) else $error("Patch ROM acknowledge held for two cycles");

endmodule

//--- cdi_address_decoder.sv
`timescale 1ns/1ps

module cdi_address_decoder (
    input  logic                 as,
    input  logic                 uds,
    input  logic                 lds,
    input  cdi_bus_pkg::addr_t   addr,
    input  logic                 rom_enabled,
    input  logic                 mpeg_ram_enabled,
    output logic                 video_cs,
    output logic                 dvc_ram_cs,
    output logic                 dvc_rom_cs,
    output logic                 mpeg_cs,
    output logic                 cdic_cs,
    output logic                 slave_cs,
    output logic                 nvram_cs,
    output logic                 rom_cs,
    output cdi_bus_pkg::target_e target,
    output logic                 bus_err
);

    logic [23:0] addr_byte;
    logic        rom_range;
    logic        err_fixed;
    logic        err_rom;
    logic        err_mpeg_ram;

    assign addr_byte = {addr, 1'b0};

    // Video RAM sits below 2.5 MiB and in the 4 MiB to 8 MiB window
    assign video_cs = ((addr_byte <= cdi_bus_pkg::VIDEO_LOW_END) ||
                       (addr_byte >= cdi_bus_pkg::VIDEO_HIGH_START)) && !addr[23] && as;

    // MPEG RAM is reached through the DVC RAM select
    assign dvc_ram_cs = ((addr_byte[23:20] == cdi_bus_pkg::DVC_RAM_NIBBLE) ||
                         (addr_byte[23:19] == cdi_bus_pkg::MPEG_RAM_CODE)) && as;
    assign dvc_rom_cs = (addr_byte[23:18] == cdi_bus_pkg::DVC_ROM_CODE) && as;
    assign mpeg_cs    = (addr_byte[23:18] == cdi_bus_pkg::MPEG_REG_CODE) && as;
    assign cdic_cs    = (addr_byte[23:16] == cdi_bus_pkg::CDIC_PAGE) && as;
    assign slave_cs   = (addr_byte[23:16] == cdi_bus_pkg::SLAVE_PAGE) && as;
    assign nvram_cs   = (addr_byte[23:16] == cdi_bus_pkg::NVRAM_PAGE) && as;

    assign rom_range = (addr_byte >= cdi_bus_pkg::ROM_BASE) &&
                       (addr_byte < cdi_bus_pkg::ROM_BASE + 2 * cdi_bus_pkg::ROM_WORDS);
    assign rom_cs    = rom_range && rom_enabled && as;

    assign err_fixed = ((addr_byte >= cdi_bus_pkg::ERR1_LOW) &&
                        (addr_byte < cdi_bus_pkg::ERR1_HIGH)) ||
                       ((addr_byte >= cdi_bus_pkg::ERR2_LOW) &&
                        (addr_byte < cdi_bus_pkg::ERR2_HIGH)) ||
                       (addr_byte >= cdi_bus_pkg::ERR3_LOW);

    // Whole upper area faults while the patch ROM is switched off
    assign err_rom      = (addr_byte >= cdi_bus_pkg::ROM_BASE) && !rom_enabled;
    assign err_mpeg_ram = (addr_byte[23:19] == cdi_bus_pkg::MPEG_RAM_CODE) && !mpeg_ram_enabled;

    assign bus_err = (err_fixed || err_rom || err_mpeg_ram) && as && (uds || lds);

    // Priority of the response path
    always_comb begin
        if (slave_cs) begin
            target = cdi_bus_pkg::TGT_SLAVE;
        end else if (cdic_cs) begin
            target = cdi_bus_pkg::TGT_CDIC;
        end else if (mpeg_cs) begin
            target = cdi_bus_pkg::TGT_VMPEG;
        end else if (nvram_cs) begin
            target = cdi_bus_pkg::TGT_NVRAM;
        end else if (video_cs || dvc_ram_cs || dvc_rom_cs) begin
            target = cdi_bus_pkg::TGT_VIDEO;
        end else if (rom_cs) begin
            target = cdi_bus_pkg::TGT_ROM;
        end else begin
            target = cdi_bus_pkg::TGT_NONE;
        end
    end

    // The three peripheral pages never overlap
    always_comb begin
        assert ($onehot0({slave_cs, cdic_cs, nvram_cs}))
            else $error("Overlapping peripheral page selects");
    end

endmodule

//--- cdi_bus_glue.sv
`timescale 1ns/1ps

module cdi_bus_glue (
    input  logic               clk30,
    input  logic               reset,

    input  logic               as,
    input  logic               uds,
    input  logic               lds,
    input  logic               write_strobe,
    input  cdi_bus_pkg::addr_t addr,

    input  cdi_bus_pkg::data_t video_dout,
    input  cdi_bus_pkg::data_t cdic_dout,
    input  cdi_bus_pkg::data_t vmpeg_dout,
    input  cdi_bus_pkg::byte_t slave_dout,
    input  cdi_bus_pkg::byte_t nvram_dout,
    input  logic               video_ack,
    input  logic               cdic_ack,
    input  logic               vmpeg_ack,
    input  logic               slave_ack,
    input  logic               nvram_ack,

    input  logic               cdic_intreq,
    input  logic               vmpeg_intreq,
    input  logic               iack4,

    input  logic               mpeg_ram_enabled,
    input  logic               cd_img_mounted,
    input  logic               config_auto_play,
    input  logic               audio_cd_in_tray,
    input  logic               slave_reset_req,

    output logic               video_cs,
    output logic               dvc_ram_cs,
    output logic               dvc_rom_cs,
    output logic               mpeg_cs,
    output logic               cdic_cs,
    output logic               slave_cs,
    output logic               nvram_cs,

    output logic               bus_ack,
    output logic               bus_err,
    output cdi_bus_pkg::data_t data_in,

    output logic               in4,
    output logic               cdic_intack,
    output logic               vmpeg_intack,

    output logic               sys_reset
);

    cdi_bus_pkg::target_e target;
    cdi_bus_pkg::data_t   rom_dout;
    logic                 rom_cs;
    logic                 rom_ack;
    logic                 rom_enabled;

    // The slave can reset the whole system through its port pin
    assign sys_reset = reset || slave_reset_req;

    cdi_address_decoder u_decoder (
        .as               (as),
        .uds              (uds),
        .lds              (lds),
        .addr             (addr),
        .rom_enabled      (rom_enabled),
        .mpeg_ram_enabled (mpeg_ram_enabled),
        .video_cs         (video_cs),
        .dvc_ram_cs       (dvc_ram_cs),
        .dvc_rom_cs       (dvc_rom_cs),
        .mpeg_cs          (mpeg_cs),
        .cdic_cs          (cdic_cs),
        .slave_cs         (slave_cs),
        .nvram_cs         (nvram_cs),
        .rom_cs           (rom_cs),
        .target           (target),
        .bus_err          (bus_err)
    );

    // External reset only, the ROM needs to tell the two reset sources apart
    boot_patch_rom u_rom (
        .clk30            (clk30),
        .reset            (reset),
        .slave_reset_req  (slave_reset_req),
        .cd_img_mounted   (cd_img_mounted),
        .config_auto_play (config_auto_play),
        .audio_cd_in_tray (audio_cd_in_tray),
        .rom_cs           (rom_cs),
        .addr             (addr),
        .rom_enabled      (rom_enabled),
        .rom_dout         (rom_dout),
        .rom_ack          (rom_ack)
    );

    cdi_read_mux u_mux (
        .target       (target),
        .video_dout   (video_dout),
        .cdic_dout    (cdic_dout),
        .vmpeg_dout   (vmpeg_dout),
        .rom_dout     (rom_dout),
        .slave_dout   (slave_dout),
        .nvram_dout   (nvram_dout),
        .video_ack    (video_ack),
        .cdic_ack     (cdic_ack),
        .vmpeg_ack    (vmpeg_ack),
        .slave_ack    (slave_ack),
        .nvram_ack    (nvram_ack),
        .rom_ack      (rom_ack),
        .cdic_intack  (cdic_intack),
        .vmpeg_intack (vmpeg_intack),
        .data_in      (data_in),
        .bus_ack      (bus_ack)
    );

    irq4_owner u_irq4 (
        .clk30        (clk30),
        .reset        (sys_reset),
        .cdic_intreq  (cdic_intreq),
        .vmpeg_intreq (vmpeg_intreq),
        .iack4        (iack4),
        .in4          (in4),
        .cdic_intack  (cdic_intack),
        .vmpeg_intack (vmpeg_intack)
    );

    // Write cycles pass through the same handshake as reads
    c_write_done: cover property (
        @(posedge clk30) disable iff (sys_reset)
        as && write_strobe && bus_ack
    );

endmodule

//--- cdi_bus_pkg.sv
package cdi_bus_pkg;

    // CPU word address, byte lane selected by the data strobes
    typedef logic [23:1] addr_t;
    typedef logic [15:0] data_t;
    typedef logic [7:0]  byte_t;

    // Target that owns the current bus cycle
    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_SLAVE,
        TGT_CDIC,
        TGT_VMPEG,
        TGT_NVRAM,
        TGT_VIDEO,
        TGT_ROM
    } target_e;

    // Owner of interrupt level 4
    typedef enum logic [1:0] {
        OWNER_IDLE,
        OWNER_CDIC,
        OWNER_VMPEG
    } irq_owner_e;

    // Video decoder main RAM windows
    localparam logic [23:0] VIDEO_LOW_END    = 24'h27FFFF;
    localparam logic [23:0] VIDEO_HIGH_START = 24'h400000;

    // DVC cartridge and MPEG areas, matched on the upper address bits
    localparam logic [3:0] DVC_RAM_NIBBLE = 4'hD;
    localparam logic [4:0] MPEG_RAM_CODE  = 5'b11101;
    localparam logic [5:0] DVC_ROM_CODE   = 6'b111001;
    localparam logic [5:0] MPEG_REG_CODE  = 6'b111000;

    // 64 KiB pages of the on-board peripherals
    localparam logic [7:0] CDIC_PAGE  = 8'h30;
    localparam logic [7:0] SLAVE_PAGE = 8'h31;
    localparam logic [7:0] NVRAM_PAGE = 8'h32;

    localparam logic [23:0] ROM_BASE = 24'hF00000;

    // Unmapped areas, low bound inclusive and high bound exclusive
    localparam logic [23:0] ERR1_LOW  = 24'h080000;
    localparam logic [23:0] ERR1_HIGH = 24'h200000;
    localparam logic [23:0] ERR2_LOW  = 24'h500000;
    localparam logic [23:0] ERR2_HIGH = 24'hD00000;
    localparam logic [23:0] ERR3_LOW  = 24'hF10000;

    localparam int ROM_WORDS     = 16;
    localparam int ROM_ADDR_BITS = 4;

endpackage

//--- cdi_read_mux.sv
`timescale 1ns/1ps

module cdi_read_mux (
    input  cdi_bus_pkg::target_e target,
    input  cdi_bus_pkg::data_t   video_dout,
    input  cdi_bus_pkg::data_t   cdic_dout,
    input  cdi_bus_pkg::data_t   vmpeg_dout,
    input  cdi_bus_pkg::data_t   rom_dout,
    input  cdi_bus_pkg::byte_t   slave_dout,
    input  cdi_bus_pkg::byte_t   nvram_dout,
    input  logic                 video_ack,
    input  logic                 cdic_ack,
    input  logic                 vmpeg_ack,
    input  logic                 slave_ack,
    input  logic                 nvram_ack,
    input  logic                 rom_ack,
    input  logic                 cdic_intack,
    input  logic                 vmpeg_intack,
    output cdi_bus_pkg::data_t   data_in,
    output logic                 bus_ack
);

    always_comb begin
        // Unmapped cycles complete at once with zero data
        data_in = '0;
        bus_ack = 1'b1;

        case (target)
            cdi_bus_pkg::TGT_SLAVE: begin
                // Byte devices drive both lanes
                data_in = {slave_dout, slave_dout};
                bus_ack = slave_ack;
            end
            cdi_bus_pkg::TGT_CDIC: begin
                data_in = cdic_dout;
                bus_ack = cdic_ack;
            end
            cdi_bus_pkg::TGT_VMPEG: begin
                data_in = vmpeg_dout;
                bus_ack = vmpeg_ack;
            end
            cdi_bus_pkg::TGT_NVRAM: begin
                data_in = {nvram_dout, nvram_dout};
                bus_ack = nvram_ack;
            end
            cdi_bus_pkg::TGT_VIDEO: begin
                data_in = video_dout;
                bus_ack = video_ack;
            end
            cdi_bus_pkg::TGT_ROM: begin
                data_in = rom_dout;
                bus_ack = rom_ack;
            end
            default: begin
                data_in = '0;
                bus_ack = 1'b1;
            end
        endcase

        // Vector fetch during interrupt acknowledge, the device puts its vector on dout
        if (cdic_intack) begin
            data_in = cdic_dout;
            bus_ack = 1'b1;
        end

        if (vmpeg_intack) begin
            data_in = vmpeg_dout;
            bus_ack = 1'b1;
        end
    end

endmodule

//--- irq4_owner.sv
`timescale 1ns/1ps

module irq4_owner (
    input  logic clk30,
    input  logic reset,
    input  logic cdic_intreq,
    input  logic vmpeg_intreq,
    input  logic iack4,
    output logic in4,
    output logic cdic_intack,
    output logic vmpeg_intack
);

    cdi_bus_pkg::irq_owner_e owner;

    // Works like a small SR flip-flop pair on the board
    always_ff @(posedge clk30) begin
        if (reset) begin
            owner <= cdi_bus_pkg::OWNER_IDLE;
        end else begin
            case (owner)
                cdi_bus_pkg::OWNER_CDIC: begin
                    if (!cdic_intreq) begin
                        owner <= cdi_bus_pkg::OWNER_IDLE;
                    end
                end
                cdi_bus_pkg::OWNER_VMPEG: begin
                    if (!vmpeg_intreq) begin
                        owner <= cdi_bus_pkg::OWNER_IDLE;
                    end
                end
                default: begin
                    // MPEG wins a tie
                    if (vmpeg_intreq) begin
                        owner <= cdi_bus_pkg::OWNER_VMPEG;
                    end else if (cdic_intreq) begin
                        owner <= cdi_bus_pkg::OWNER_CDIC;
                    end
                end
            endcase
        end
    end

    assign in4 = ((owner == cdi_bus_pkg::OWNER_CDIC) && cdic_intreq) ||
                 ((owner == cdi_bus_pkg::OWNER_VMPEG) && vmpeg_intreq);

    assign cdic_intack  = iack4 && (owner == cdi_bus_pkg::OWNER_CDIC);
    assign vmpeg_intack = iack4 && (owner == cdi_bus_pkg::OWNER_VMPEG);

    a_one_intack: assert property (
        @(posedge clk30) disable iff (reset)
        !(cdic_intack && vmpeg_intack)
    ) else $error("Both level 4 sources acknowledged");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_cdi_bus_glue -f sources.f -o sim_cdi_bus_glue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cdi_bus_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1

//--- sources.f
cdi_bus_pkg.sv
cdi_address_decoder.sv
boot_patch_rom.sv
cdi_read_mux.sv
irq4_owner.sv
cdi_bus_glue.sv
tb_cdi_bus_glue.sv

//--- tb_cdi_bus_glue.sv
`timescale 1ns/1ps

module tb_cdi_bus_glue;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int WAIT_LIMIT     = 64;
    localparam int RANDOM_CYCLES  = 470;

    typedef struct packed {
        logic [6:0]           cs;
        cdi_bus_pkg::target_e target;
        logic                 err;
        cdi_bus_pkg::data_t   data;
        logic                 ack;
    } resp_t;

    logic clk30 = 1'b0;
    logic reset;
    logic as, uds, lds, write_strobe;
    cdi_bus_pkg::addr_t addr;
    cdi_bus_pkg::data_t video_dout, cdic_dout, vmpeg_dout;
    cdi_bus_pkg::byte_t slave_dout, nvram_dout;
    logic video_ack, cdic_ack, vmpeg_ack, slave_ack, nvram_ack;
    logic cdic_intreq, vmpeg_intreq, iack4;
    logic mpeg_ram_enabled, cd_img_mounted, config_auto_play, audio_cd_in_tray;
    logic slave_reset_req;
    logic video_cs, dvc_ram_cs, dvc_rom_cs, mpeg_cs, cdic_cs, slave_cs, nvram_cs;
    logic bus_ack, bus_err;
    cdi_bus_pkg::data_t data_in;
    logic in4, cdic_intack, vmpeg_intack, sys_reset;

    // Model state kept next to the DUT
    logic                    rom_blocked_m = 1'b0;
    logic                    rom_ack_m = 1'b0;
    logic                    rom_en_m;
    cdi_bus_pkg::irq_owner_e owner_m = cdi_bus_pkg::OWNER_IDLE;
    cdi_bus_pkg::data_t      rom_image [16];

    logic        checks_on = 1'b0;
    logic        irq_random = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          cycle_count = 0;
    logic [31:0] rnd;

    logic [23:0] boundary_addrs [33] = '{
        24'h000000, 24'h07FFFE, 24'h080000, 24'h1FFFFE, 24'h200000, 24'h27FFFE,
        24'h280000, 24'h2FFFFE, 24'h300000, 24'h30FFFE, 24'h310000, 24'h320000,
        24'h32FFFE, 24'h330000, 24'h3FFFFE, 24'h400000, 24'h4FFFFE, 24'h500000,
        24'h7FFFFE, 24'h800000, 24'hCFFFFE, 24'hD00000, 24'hDFFFFE, 24'hE00000,
        24'hE3FFFE, 24'hE40000, 24'hE80000, 24'hEFFFFE, 24'hF00000, 24'hF0001E,
        24'hF00020, 24'hF10000, 24'hFFFFFE
    };

    cdi_bus_glue DUT (.*);

    always #50 clk30 = ~clk30;

    initial $readmemh("boot_patch.mem", rom_image);

    assign rom_en_m = cd_img_mounted && config_auto_play && !audio_cd_in_tray && !rom_blocked_m;

    // Expected bus response from the address map and the modeled state
    function automatic resp_t expected_response(
        input cdi_bus_pkg::addr_t a,
        input logic strobe_as,
        input logic strobe_u,
        input logic strobe_l,
        input logic ram_en,
        input logic rom_en,
        input cdi_bus_pkg::irq_owner_e own,
        input logic iack
    );
        logic [23:0] b;
        logic        rom_hit;
        resp_t       r;
        b = {a, 1'b0};
        r = '0;
        r.cs[6] = strobe_as && ((b < 24'h280000) || (b >= 24'h400000 && b < 24'h800000));
        r.cs[5] = strobe_as && ((b[23:20] == 4'hD) || (b >= 24'hE80000 && b < 24'hF00000));
        r.cs[4] = strobe_as && (b >= 24'hE40000) && (b < 24'hE80000);
        r.cs[3] = strobe_as && (b >= 24'hE00000) && (b < 24'hE40000);
        r.cs[2] = strobe_as && (b[23:16] == 8'h30);
        r.cs[1] = strobe_as && (b[23:16] == 8'h31);
        r.cs[0] = strobe_as && (b[23:16] == 8'h32);
        rom_hit = strobe_as && rom_en && (b >= 24'hF00000) && (b < 24'hF00020);
        r.err = strobe_as && (strobe_u || strobe_l) &&
                ((b >= 24'h080000 && b < 24'h200000) || (b >= 24'h500000 && b < 24'hD00000) ||
                 (b >= 24'hF10000) || (b >= 24'hF00000 && !rom_en) ||
                 (b >= 24'hE80000 && b < 24'hF00000 && !ram_en));
        if (r.cs[1]) r.target = cdi_bus_pkg::TGT_SLAVE;
        else if (r.cs[2]) r.target = cdi_bus_pkg::TGT_CDIC;
        else if (r.cs[3]) r.target = cdi_bus_pkg::TGT_VMPEG;
        else if (r.cs[0]) r.target = cdi_bus_pkg::TGT_NVRAM;
        else if (r.cs[6] || r.cs[5] || r.cs[4]) r.target = cdi_bus_pkg::TGT_VIDEO;
        else if (rom_hit) r.target = cdi_bus_pkg::TGT_ROM;
        else r.target = cdi_bus_pkg::TGT_NONE;
        case (r.target)
            cdi_bus_pkg::TGT_SLAVE: r.data = {slave_dout, slave_dout};
            cdi_bus_pkg::TGT_CDIC:  r.data = cdic_dout;
            cdi_bus_pkg::TGT_VMPEG: r.data = vmpeg_dout;
            cdi_bus_pkg::TGT_NVRAM: r.data = {nvram_dout, nvram_dout};
            cdi_bus_pkg::TGT_VIDEO: r.data = video_dout;
            cdi_bus_pkg::TGT_ROM:   r.data = rom_image[a[4:1]];
            default:                r.data = 16'h0000;
        endcase
        case (r.target)
            cdi_bus_pkg::TGT_SLAVE: r.ack = slave_ack;
            cdi_bus_pkg::TGT_CDIC:  r.ack = cdic_ack;
            cdi_bus_pkg::TGT_VMPEG: r.ack = vmpeg_ack;
            cdi_bus_pkg::TGT_NVRAM: r.ack = nvram_ack;
            cdi_bus_pkg::TGT_VIDEO: r.ack = video_ack;
            cdi_bus_pkg::TGT_ROM:   r.ack = rom_ack_m;
            default:                r.ack = 1'b1;
        endcase
        // The interrupt vector replaces the normal response
        if (iack && own == cdi_bus_pkg::OWNER_VMPEG) begin
            r.data = vmpeg_dout;
            r.ack  = 1'b1;
        end else if (iack && own == cdi_bus_pkg::OWNER_CDIC) begin
            r.data = cdic_dout;
            r.ack  = 1'b1;
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ROM acknowledge, auto-play block and level 4 owner as the bus rules describe them
    always @(posedge clk30) begin
        if (reset) begin
            rom_blocked_m <= 1'b0;
        end else if (slave_reset_req) begin
            rom_blocked_m <= 1'b1;
        end
        if (reset || slave_reset_req) begin
            rom_ack_m <= 1'b0;
            owner_m   <= cdi_bus_pkg::OWNER_IDLE;
        end else begin
            rom_ack_m <= as && rom_en_m && ({addr, 1'b0} >= 24'hF00000) &&
                         ({addr, 1'b0} < 24'hF00020) && !rom_ack_m;
            if (owner_m == cdi_bus_pkg::OWNER_IDLE) begin
                if (vmpeg_intreq) owner_m <= cdi_bus_pkg::OWNER_VMPEG;
                else if (cdic_intreq) owner_m <= cdi_bus_pkg::OWNER_CDIC;
            end else if (owner_m == cdi_bus_pkg::OWNER_CDIC && !cdic_intreq) begin
                owner_m <= cdi_bus_pkg::OWNER_IDLE;
            end else if (owner_m == cdi_bus_pkg::OWNER_VMPEG && !vmpeg_intreq) begin
                owner_m <= cdi_bus_pkg::OWNER_IDLE;
            end
        end
    end

    // Device models with random data and acknowledge
    always @(posedge clk30) begin
        logic [31:0] d;
        logic [31:0] k;
        d = $urandom();
        k = $urandom();
        video_dout <= d[15:0];
        cdic_dout  <= d[31:16];
        vmpeg_dout <= k[31:16];
        slave_dout <= k[7:0];
        nvram_dout <= k[15:8];
        video_ack  <= d[0] ^ k[0];
        cdic_ack   <= d[1] ^ k[1];
        vmpeg_ack  <= d[2] ^ k[2];
        slave_ack  <= d[3] ^ k[3];
        nvram_ack  <= d[4] ^ k[4];
        if (irq_random && k[20:17] == 4'h0) cdic_intreq <= !cdic_intreq;
        if (irq_random && k[24:21] == 4'h0) vmpeg_intreq <= !vmpeg_intreq;
    end

    // Compare on the falling edge once all outputs have settled
    always @(negedge clk30) begin
        resp_t exp_r;
        if (checks_on) begin
            exp_r = expected_response(addr, as, uds, lds, mpeg_ram_enabled, rom_en_m,
                                      owner_m, iack4);
            check_value("video_cs", video_cs, exp_r.cs[6]);
            check_value("dvc_ram_cs", dvc_ram_cs, exp_r.cs[5]);
            check_value("dvc_rom_cs", dvc_rom_cs, exp_r.cs[4]);
            check_value("mpeg_cs", mpeg_cs, exp_r.cs[3]);
            check_value("cdic_cs", cdic_cs, exp_r.cs[2]);
            check_value("slave_cs", slave_cs, exp_r.cs[1]);
            check_value("nvram_cs", nvram_cs, exp_r.cs[0]);
            check_value("target", DUT.target, exp_r.target);
            check_value("bus_err", bus_err, exp_r.err);
            check_value("bus_ack", bus_ack, exp_r.ack);
            if (exp_r.ack) check_value("data_in", data_in, exp_r.data);
            check_value("in4", in4, (owner_m == cdi_bus_pkg::OWNER_CDIC && cdic_intreq) ||
                                    (owner_m == cdi_bus_pkg::OWNER_VMPEG && vmpeg_intreq));
            check_value("cdic_intack", cdic_intack, iack4 && owner_m == cdi_bus_pkg::OWNER_CDIC);
            check_value("vmpeg_intack", vmpeg_intack,
                        iack4 && owner_m == cdi_bus_pkg::OWNER_VMPEG);
            check_value("sys_reset", sys_reset, reset || slave_reset_req);
        end
    end

    always @(posedge clk30) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    // One CPU cycle held until acknowledge or bus error
    task automatic run_bus_cycle(input cdi_bus_pkg::addr_t a, input logic u, input logic l,
                                 input logic w, input logic iack, output int edges);
        @(posedge clk30);
        as           <= 1'b1;
        uds          <= u;
        lds          <= l;
        write_strobe <= w;
        iack4        <= iack;
        addr         <= a;
        edges = 0;
        @(negedge clk30);
        while (!(bus_ack || bus_err) && edges < WAIT_LIMIT) begin
            @(posedge clk30);
            edges++;
            @(negedge clk30);
        end
        if (!(bus_ack || bus_err)) begin
            errors++;
            $display("Bus cycle at byte address %h got neither acknowledge nor bus error",
                     {a, 1'b0});
        end
    endtask

    task automatic end_bus_cycle();
        @(posedge clk30);
        as    <= 1'b0;
        uds   <= 1'b0;
        lds   <= 1'b0;
        iack4 <= 1'b0;
    endtask

    task automatic set_status(input logic mounted, input logic auto, input logic tray,
                              input logic ram_en);
        @(posedge clk30);
        cd_img_mounted   <= mounted;
        config_auto_play <= auto;
        audio_cd_in_tray <= tray;
        mpeg_ram_enabled <= ram_en;
    endtask

    task automatic read_rom_word(input int idx);
        int edges;
        run_bus_cycle(23'h780000 + 23'(idx), 1'b1, 1'b1, 1'b0, 1'b0, edges);
        check_value("ROM acknowledge delay", edges, 1);
        check_value("ROM word", data_in, rom_image[idx]);
        end_bus_cycle();
    endtask

    task automatic expect_rom_error(input int idx);
        int edges;
        run_bus_cycle(23'h780000 + 23'(idx), 1'b1, 1'b1, 1'b0, 1'b0, edges);
        check_value("bus_err on blocked ROM", bus_err, 1'b1);
        end_bus_cycle();
    endtask

    task automatic pulse_input(input bit use_slave, input int len);
        @(posedge clk30);
        if (use_slave) slave_reset_req <= 1'b1;
        else reset <= 1'b1;
        repeat (len) @(posedge clk30);
        slave_reset_req <= 1'b0;
        reset           <= 1'b0;
    endtask

    // Vector of the expected owner, taken from its device model in the acknowledge cycle
    task automatic iack_vector(input cdi_bus_pkg::irq_owner_e expected_owner);
        int edges;
        run_bus_cycle(23'h000000, 1'b1, 1'b1, 1'b0, 1'b1, edges);
        if (expected_owner == cdi_bus_pkg::OWNER_VMPEG) begin
            check_value("level 4 vector", data_in, vmpeg_dout);
        end else begin
            check_value("level 4 vector", data_in, cdic_dout);
        end
        check_value("iack acknowledge delay", edges, 0);
        end_bus_cycle();
    endtask

    initial begin
        cdi_bus_pkg::addr_t a;
        logic [31:0]        ctrl;
        int                 edges;
        rnd = $urandom(32'h6c81);
        reset = 1'b1;
        {as, uds, lds, write_strobe, iack4} = '0;
        addr = '0;
        {video_dout, cdic_dout, vmpeg_dout, slave_dout, nvram_dout} = '0;
        {video_ack, cdic_ack, vmpeg_ack, slave_ack, nvram_ack} = '0;
        {cdic_intreq, vmpeg_intreq, slave_reset_req} = '0;
        {cd_img_mounted, config_auto_play, audio_cd_in_tray, mpeg_ram_enabled} = 4'b1101;
        repeat (16) @(posedge clk30);
        reset     <= 1'b0;
        checks_on <= 1'b1;

        // Every map boundary once and then random cycles
        for (int i = 0; i < 33; i++) begin
            run_bus_cycle(boundary_addrs[i][23:1], 1'b1, 1'b0, 1'b0, 1'b0, edges);
            end_bus_cycle();
        end
        irq_random <= 1'b1;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            if (i % 16 == 0) begin
                rnd = $urandom();
                set_status(rnd[2:0] != 0, rnd[5:3] != 0, rnd[8:6] == 0, rnd[9]);
            end
            ctrl = $urandom();
            rnd  = $urandom();
            case (ctrl[1:0])
                2'd0: a = boundary_addrs[rnd[31:8] % 33][23:1];
                2'd1: a = 23'h780000 + {18'd0, rnd[8:4]};
                2'd2: a = {8'h30 | {6'd0, rnd[5:4]}, rnd[22:8]};
                default: a = rnd[30:8];
            endcase
            run_bus_cycle(a, ctrl[2], ctrl[3], ctrl[4], ctrl[7:5] == 0, edges);
            end_bus_cycle();
        end

        // Patch ROM with auto-play conditions met
        irq_random <= 1'b0;
        set_status(1'b1, 1'b1, 1'b0, 1'b1);
        for (int i = 0; i < 16; i++) read_rom_word(i);

        // Auto-play blocking
        pulse_input(1'b1, 1);
        expect_rom_error(2);
        pulse_input(1'b0, 2);
        read_rom_word(3);
        set_status(1'b1, 1'b1, 1'b1, 1'b1);
        expect_rom_error(4);
        set_status(1'b0, 1'b1, 1'b0, 1'b1);
        expect_rom_error(5);
        set_status(1'b1, 1'b1, 1'b0, 1'b1);
        read_rom_word(6);

        // Level 4 sharing with single and overlapping requests
        @(posedge clk30);
        cdic_intreq  <= 1'b0;
        vmpeg_intreq <= 1'b0;
        repeat (2) @(posedge clk30);
        cdic_intreq <= 1'b1;
        repeat (2) @(posedge clk30);
        iack_vector(cdi_bus_pkg::OWNER_CDIC);
        vmpeg_intreq <= 1'b1;
        repeat (2) @(posedge clk30);
        iack_vector(cdi_bus_pkg::OWNER_CDIC);
        cdic_intreq <= 1'b0;
        repeat (3) @(posedge clk30);
        iack_vector(cdi_bus_pkg::OWNER_VMPEG);
        vmpeg_intreq <= 1'b0;
        repeat (2) @(posedge clk30);
        cdic_intreq  <= 1'b1;
        vmpeg_intreq <= 1'b1;
        repeat (2) @(posedge clk30);
        iack_vector(cdi_bus_pkg::OWNER_VMPEG);
        cdic_intreq  <= 1'b0;
        vmpeg_intreq <= 1'b0;
        repeat (3) @(posedge clk30);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
